// ==== hdl/bus_pkg.sv ====
package bus_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Address and data of the shared word store
  localparam int ADDR_W = 8;
  localparam int DATA_W = 8;

  ////////////////////////////////////////
  // Command port
  ////////////////////////////////////////

  // Operation requested on a master command port
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_BUMP  = 2'd2
  } op_t;

  // Command into a master; for a bump, wdata is the amount added
  typedef struct packed {
    op_t               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } master_cmd_t;

  ////////////////////////////////////////
  // Memory bus
  ////////////////////////////////////////

  // Request from a master, passed on by the arbiter to the store
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              lock;
  } bus_req_t;

  // Record of the last completed memory access, for the display
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } bus_trace_t;

endpackage

// ==== hdl/bus_master.sv ====
`timescale 1ns/1ps

module bus_master (
  input  logic                       clk,
  input  logic                       reset,
  input  bus_pkg::master_cmd_t       cmd,
  input  logic                       cmd_req,
  input  logic                       bus_ack,
  input  logic [bus_pkg::DATA_W-1:0] bus_rdata,
  output logic                       cmd_ack,
  output logic [bus_pkg::DATA_W-1:0] rsp,
  output logic                       bus_req,
  output bus_pkg::bus_req_t          bus
);
  import bus_pkg::*;

  typedef enum logic [2:0] {
    M_IDLE,
    M_FIRST,
    M_SECOND,
    M_DONE,
    M_RELEASE
  } mst_state_t;

  mst_state_t        state;
  logic [DATA_W-1:0] sum;
  logic              bus_done;

  // Write-back value of a bump, old word plus amount
  assign sum = rsp + cmd.wdata;

  // Both halves of the bus handshake are back low
  assign bus_done = !bus_req && !bus_ack;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= M_IDLE;
      bus_req <= 1'b0;
      cmd_ack <= 1'b0;
    end else begin
      case (state)
        M_IDLE: begin
          if (cmd_req) begin
            bus_req <= 1'b1;
            state   <= M_FIRST;
          end
        end
        M_FIRST: begin
          if (bus_req && bus_ack) begin
            bus_req <= 1'b0;
          end else if (bus_done) begin
            // Bump goes on to its unlocked write-back
            if (cmd.op == OP_BUMP) begin
              bus_req <= 1'b1;
              state   <= M_SECOND;
            end else begin
              state <= M_DONE;
            end
          end
        end
        M_SECOND: begin
          if (bus_req && bus_ack) begin
            bus_req <= 1'b0;
          end else if (bus_done) begin
            state <= M_DONE;
          end
        end
        M_DONE: begin
          cmd_ack <= 1'b1;
          state   <= M_RELEASE;
        end
        M_RELEASE: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= M_IDLE;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Bus payload and response
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state == M_IDLE && cmd_req) begin
      bus.write <= (cmd.op == OP_WRITE);
      bus.addr  <= cmd.addr;
      bus.wdata <= cmd.wdata;
      // read half of a bump holds the store until the write-back
      bus.lock  <= (cmd.op == OP_BUMP);
    end
    if (state == M_FIRST && bus_req && bus_ack) begin
      rsp <= (cmd.op == OP_WRITE) ? cmd.wdata : bus_rdata;
    end
    if (state == M_FIRST && bus_done && cmd.op == OP_BUMP) begin
      bus.write <= 1'b1;
      bus.wdata <= sum;
      bus.lock  <= 1'b0;
    end
  end

endmodule

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_a,
  input  logic                       req_b,
  input  bus_pkg::bus_req_t          bus_a,
  input  bus_pkg::bus_req_t          bus_b,
  input  logic                       mem_ack,
  input  logic [bus_pkg::DATA_W-1:0] mem_rdata,
  output logic                       ack_a,
  output logic                       ack_b,
  output logic [bus_pkg::DATA_W-1:0] rdata_a,
  output logic [bus_pkg::DATA_W-1:0] rdata_b,
  output logic                       mem_req,
  output bus_pkg::bus_req_t          mem_bus,
  output bus_pkg::bus_trace_t        trace
);
  import bus_pkg::*;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_WAIT_ACK,
    ARB_WAIT_REQ_LOW,
    ARB_WAIT_ACK_LOW
  } arb_state_t;

  arb_state_t        state;
  logic              owner;      // 0 for master A, 1 for master B
  logic              ptr;        // master with priority on a tie
  logic              locked;
  logic              grant_any;
  logic              grant_sel;
  logic              req_owner;
  logic [DATA_W-1:0] rdata_owner;

  assign req_owner   = owner ? req_b : req_a;
  assign rdata_owner = owner ? rdata_b : rdata_a;

  // Pick the next master; a held lock admits only its owner
  always_comb begin
    grant_any = 1'b0;
    grant_sel = 1'b0;
    if (locked) begin
      grant_any = req_owner;
      grant_sel = owner;
    end else if (req_a && req_b) begin
      grant_any = 1'b1;
      grant_sel = ptr;
    end else if (req_a || req_b) begin
      grant_any = 1'b1;
      grant_sel = req_b;
    end
  end

  ////////////////////////////////////////
  // Handshake relay
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ARB_IDLE;
      owner   <= 1'b0;
      ptr     <= 1'b0;
      locked  <= 1'b0;
      mem_req <= 1'b0;
      ack_a   <= 1'b0;
      ack_b   <= 1'b0;
      trace   <= '0;
    end else begin
      case (state)
        // Memory side is idle here, req and ack both low
        ARB_IDLE: begin
          if (grant_any) begin
            owner   <= grant_sel;
            ptr     <= ~grant_sel;
            mem_req <= 1'b1;
            state   <= ARB_WAIT_ACK;
          end
        end
        ARB_WAIT_ACK: begin
          if (mem_ack) begin
            ack_a <= ~owner;
            ack_b <= owner;
            state <= ARB_WAIT_REQ_LOW;
          end
        end
        ARB_WAIT_REQ_LOW: begin
          if (!req_owner) begin
            mem_req <= 1'b0;
            state   <= ARB_WAIT_ACK_LOW;
          end
        end
        ARB_WAIT_ACK_LOW: begin
          if (!mem_ack) begin
            ack_a       <= 1'b0;
            ack_b       <= 1'b0;
            locked      <= mem_bus.lock;
            trace.addr  <= mem_bus.addr;
            trace.data  <= mem_bus.write ? mem_bus.wdata : rdata_owner;
            state       <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // Request payload and read data toward the masters
  always_ff @(posedge clk) begin
    if (state == ARB_IDLE && grant_any) begin
      mem_bus <= grant_sel ? bus_b : bus_a;
    end
    if (state == ARB_WAIT_ACK && mem_ack) begin
      if (owner) begin
        rdata_b <= mem_rdata;
      end else begin
        rdata_a <= mem_rdata;
      end
    end
  end

endmodule

// ==== hdl/word_store.sv ====
`timescale 1ns/1ps

module word_store #(
  parameter int DEPTH = 256
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req,
  input  bus_pkg::bus_req_t          bus,
  output logic                       ack,
  output logic [bus_pkg::DATA_W-1:0] rdata
);
  import bus_pkg::*;

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [IDX_W-1:0]  idx;
  logic              start;

  // Addresses past the end wrap around
  assign idx = IDX_W'(bus.addr % DEPTH);

  // New request seen, ack about to rise
  assign start = req && !ack;

  ////////////////////////////////////////
  // Four-phase acknowledge
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else if (start) begin
      ack <= 1'b1;
    end else if (!req && ack) begin
      ack <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Memory array
  ////////////////////////////////////////

  // Access happens on the edge that raises ack
  always_ff @(posedge clk) begin
    if (start) begin
      if (bus.write) begin
        mem[idx] <= bus.wdata;
      end else begin
        rdata <= mem[idx];
      end
    end
  end

endmodule

// ==== hdl/seg_scan.sv ====
`timescale 1ns/1ps

module seg_scan #(
  parameter int SCAN_DIV = 500
) (
  input  logic                clk,
  input  logic                reset,
  input  bus_pkg::bus_trace_t trace,
  output logic [6:0]          cathode,
  output logic [3:0]          anode
);

  localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  logic [CNT_W-1:0] cnt;
  logic             tick;
  logic [1:0]       digit;
  logic [3:0]       nibble;

  // Hex digit to segments a..g, active low
  function automatic logic [6:0] hex_to_seg(input logic [3:0] value);
    case (value)
      4'h0:    hex_to_seg = 7'b0000001;
      4'h1:    hex_to_seg = 7'b1001111;
      4'h2:    hex_to_seg = 7'b0010010;
      4'h3:    hex_to_seg = 7'b0000110;
      4'h4:    hex_to_seg = 7'b1001100;
      4'h5:    hex_to_seg = 7'b0100100;
      4'h6:    hex_to_seg = 7'b0100000;
      4'h7:    hex_to_seg = 7'b0001111;
      4'h8:    hex_to_seg = 7'b0000000;
      4'h9:    hex_to_seg = 7'b0000100;
      4'ha:    hex_to_seg = 7'b0001000;
      4'hb:    hex_to_seg = 7'b1100000;
      4'hc:    hex_to_seg = 7'b0110001;
      4'hd:    hex_to_seg = 7'b1000010;
      4'he:    hex_to_seg = 7'b0110000;
      default: hex_to_seg = 7'b0111000;
    endcase
  endfunction

  ////////////////////////////////////////
  // Scan tick and digit index
  ////////////////////////////////////////

  assign tick = (cnt == CNT_W'(SCAN_DIV - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt   <= '0;
      digit <= 2'd0;
    end else if (tick) begin
      cnt   <= '0;
      digit <= digit + 2'd1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Digits 3..0 are addr high, addr low, data high, data low
  always_comb begin
    case (digit)
      2'd0:    nibble = trace.data[3:0];
      2'd1:    nibble = trace.data[7:4];
      2'd2:    nibble = trace.addr[3:0];
      default: nibble = trace.addr[7:4];
    endcase
  end

  // Registered together so anode and cathode switch on the same edge
  always_ff @(posedge clk) begin
    if (reset) begin
      anode   <= 4'b1111;
      cathode <= 7'b1111111;
    end else begin
      anode   <= ~(4'b0001 << digit);
      cathode <= hex_to_seg(nibble);
    end
  end

endmodule

// ==== hdl/shared_mem_top.sv ====
`timescale 1ns/1ps

module shared_mem_top #(
  parameter int DEPTH    = 256,
  parameter int SCAN_DIV = 500
) (
  input  logic                       clk,
  input  logic                       reset,
  input  bus_pkg::master_cmd_t       cmd_a,
  input  logic                       cmd_req_a,
  input  bus_pkg::master_cmd_t       cmd_b,
  input  logic                       cmd_req_b,
  output logic                       cmd_ack_a,
  output logic [bus_pkg::DATA_W-1:0] rsp_a,
  output logic                       cmd_ack_b,
  output logic [bus_pkg::DATA_W-1:0] rsp_b,
  output logic [6:0]                 cathode,
  output logic [3:0]                 anode
);
  import bus_pkg::*;

  // Master to arbiter
  logic              req_a;
  logic              req_b;
  logic              ack_a;
  logic              ack_b;
  bus_req_t          bus_a;
  bus_req_t          bus_b;
  logic [DATA_W-1:0] rdata_a;
  logic [DATA_W-1:0] rdata_b;

  // Arbiter to store and display
  logic              mem_req;
  logic              mem_ack;
  bus_req_t          mem_bus;
  logic [DATA_W-1:0] mem_rdata;
  bus_trace_t        trace;

  bus_master master_a (
    .clk, .reset,
    .cmd       (cmd_a),
    .cmd_req   (cmd_req_a),
    .bus_ack   (ack_a),
    .bus_rdata (rdata_a),
    .cmd_ack   (cmd_ack_a),
    .rsp       (rsp_a),
    .bus_req   (req_a),
    .bus       (bus_a)
  );

  bus_master master_b (
    .clk, .reset,
    .cmd       (cmd_b),
    .cmd_req   (cmd_req_b),
    .bus_ack   (ack_b),
    .bus_rdata (rdata_b),
    .cmd_ack   (cmd_ack_b),
    .rsp       (rsp_b),
    .bus_req   (req_b),
    .bus       (bus_b)
  );

  bus_arbiter arbiter (
    .clk, .reset,
    .req_a, .req_b, .bus_a, .bus_b,
    .mem_ack, .mem_rdata,
    .ack_a, .ack_b, .rdata_a, .rdata_b,
    .mem_req, .mem_bus, .trace
  );

  word_store #(.DEPTH(DEPTH)) store (
    .clk, .reset,
    .req   (mem_req),
    .bus   (mem_bus),
    .ack   (mem_ack),
    .rdata (mem_rdata)
  );

  seg_scan #(.SCAN_DIV(SCAN_DIV)) scanner (
    .clk, .reset, .trace, .cathode, .anode
  );

endmodule

// ==== bench/shared_mem_sva.sv ====
`timescale 1ns/1ps

module shared_mem_sva (
  input logic                 clk,
  input logic                 reset,
  input bus_pkg::master_cmd_t cmd_a,
  input bus_pkg::master_cmd_t cmd_b,
  input logic                 cmd_req_a,
  input logic                 cmd_req_b,
  input logic                 cmd_ack_a,
  input logic                 cmd_ack_b,
  input logic [7:0]           rsp_a,
  input logic [7:0]           rsp_b,
  input logic [3:0]           anode
);

  ////////////////////////////////////////
  // Command port handshakes
  ////////////////////////////////////////

  a_rise_a: assert property (@(posedge clk) disable iff (reset) $rose(cmd_ack_a) |-> cmd_req_a)
    else $error("cmd_ack_a rose without cmd_req_a");
  a_rise_b: assert property (@(posedge clk) disable iff (reset) $rose(cmd_ack_b) |-> cmd_req_b)
    else $error("cmd_ack_b rose without cmd_req_b");
  a_fall_a: assert property (@(posedge clk) disable iff (reset) $fell(cmd_ack_a) |-> !cmd_req_a)
    else $error("cmd_ack_a fell while cmd_req_a high");
  a_fall_b: assert property (@(posedge clk) disable iff (reset) $fell(cmd_ack_b) |-> !cmd_req_b)
    else $error("cmd_ack_b fell while cmd_req_b high");
  a_hold_a: assert property (@(posedge clk) disable iff (reset)
    cmd_ack_a && $past(cmd_ack_a) |-> $stable(cmd_a) && $stable(rsp_a))
    else $error("port A payload changed while cmd_ack_a high");
  a_hold_b: assert property (@(posedge clk) disable iff (reset)
    cmd_ack_b && $past(cmd_ack_b) |-> $stable(cmd_b) && $stable(rsp_b))
    else $error("port B payload changed while cmd_ack_b high");

  ////////////////////////////////////////
  // Display
  ////////////////////////////////////////

  a_dark: assert property (@(posedge clk) $past(reset) |-> anode == 4'b1111)
    else $error("anode active during reset");
  a_one: assert property (@(posedge clk) !reset && !$past(reset) |-> $onehot(~anode))
    else $error("anode not exactly one digit");

endmodule

bind shared_mem_top shared_mem_sva sva (
  .clk, .reset, .cmd_a, .cmd_b, .cmd_req_a, .cmd_req_b,
  .cmd_ack_a, .cmd_ack_b, .rsp_a, .rsp_b, .anode
);

// ==== bench/tb_shared_mem.sv ====
`timescale 1ns/1ps

module tb_shared_mem;
  import bus_pkg::*;

  localparam int SCAN_DIV = 4;
  localparam int N_CMDS   = 227;
  localparam int LIMIT    = 40 * N_CMDS + 5;

  logic        clk;
  logic        reset;
  master_cmd_t cmd_a;
  master_cmd_t cmd_b;
  logic        cmd_req_a;
  logic        cmd_req_b;
  logic        cmd_ack_a;
  logic        cmd_ack_b;
  logic [7:0]  rsp_a;
  logic [7:0]  rsp_b;
  logic [6:0]  cathode;
  logic [3:0]  anode;

  logic [7:0]  ref_mem [256];
  bit          written [256];
  int          issued [2];
  int          done_cnt [2];
  logic [1:0]  ack_prev;
  logic [7:0]  exp_addr;
  logic [7:0]  exp_data;
  logic [31:0] lfsr = 32'hdc168dab;
  int          cycles;
  int          errors;

  shared_mem_top #(.DEPTH(256), .SCAN_DIV(SCAN_DIV)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hung run guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  // Each rising cmd_ack counts as one completion
  always @(posedge clk) begin
    ack_prev <= {cmd_ack_b, cmd_ack_a};
    if (cmd_ack_a && !ack_prev[0]) begin
      done_cnt[0] <= done_cnt[0] + 1;
    end
    if (cmd_ack_b && !ack_prev[1]) begin
      done_cnt[1] <= done_cnt[1] + 1;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
    end
    return r;
  endfunction

  // Segments a..g, active low
  function automatic logic [6:0] seg_shape(input logic [3:0] v);
    logic [6:0] shapes [16];
    shapes = '{7'h01, 7'h4f, 7'h12, 7'h06, 7'h4c, 7'h24, 7'h20, 7'h0f,
               7'h00, 7'h04, 7'h08, 7'h60, 7'h31, 7'h42, 7'h30, 7'h38};
    return shapes[v];
  endfunction

  task automatic report_mismatch(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
    errors++;
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic run_cmd(input bit port, input op_t op, input logic [7:0] addr,
                         input logic [7:0] data, input bit check);
    master_cmd_t c;
    logic [7:0]  old;
    logic [7:0]  got;
    logic [7:0]  exp;
    c = '{op: op, addr: addr, wdata: data};
    issued[port]++;
    @(posedge clk);
    if (port) begin
      cmd_b <= c;
      cmd_req_b <= 1'b1;
    end else begin
      cmd_a <= c;
      cmd_req_a <= 1'b1;
    end
    do @(posedge clk); while (!(port ? cmd_ack_b : cmd_ack_a));
    got = port ? rsp_b : rsp_a;
    old = ref_mem[addr];
    exp = (op == OP_WRITE) ? data : old;
    if (check || op != OP_BUMP)
      assert (got === exp) else report_mismatch(port ? "rsp_b" : "rsp_a", got, exp);
    if (op == OP_WRITE) ref_mem[addr] = data;
    if (op == OP_BUMP) ref_mem[addr] = old + data;
    written[addr] = 1'b1;
    exp_addr = addr;
    exp_data = ref_mem[addr];
    if (port) cmd_req_b <= 1'b0;
    else cmd_req_a <= 1'b0;
    do @(posedge clk); while (port ? cmd_ack_b : cmd_ack_a);
  endtask

  // Each port stays in its own address half so the model order is exact
  task automatic run_random(input bit port, input int n);
    logic [7:0] addr;
    op_t        op;
    for (int i = 0; i < n; i++) begin
      op = op_t'(rand_bits(2) % 3);
      addr = {port, 7'(rand_bits(7))};
      if (!written[addr]) op = OP_WRITE;
      run_cmd(port, op, addr, 8'(rand_bits(8)), 1'b1);
    end
  endtask

  task automatic check_display();
    logic [3:0] nib;
    repeat (2) @(posedge clk);
    repeat (4 * SCAN_DIV) begin
      @(negedge clk);
      case (anode)
        4'b1110: nib = exp_data[3:0];
        4'b1101: nib = exp_data[7:4];
        4'b1011: nib = exp_addr[3:0];
        default: nib = exp_addr[7:4];
      endcase
      assert (cathode === seg_shape(nib))
        else report_mismatch("cathode", 8'(cathode), 8'(seg_shape(nib)));
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [7:0] amt_a;
    logic [7:0] amt_b;
    reset <= 1'b1;
    cmd_a <= '0;
    cmd_b <= '0;
    cmd_req_a <= 1'b0;
    cmd_req_b <= 1'b0;
    errors = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // Write on one port, read back on the other
    run_cmd(0, OP_WRITE, 8'h3c, 8'ha5, 1'b1);
    run_cmd(1, OP_READ, 8'h3c, 8'h00, 1'b1);
    check_display();
    run_cmd(1, OP_WRITE, 8'hc7, 8'h5e, 1'b1);
    run_cmd(0, OP_READ, 8'hc7, 8'h00, 1'b1);
    check_display();

    // Bump returns the old word
    run_cmd(0, OP_BUMP, 8'h3c, 8'h70, 1'b1);
    check_display();
    run_cmd(1, OP_READ, 8'h3c, 8'h00, 1'b1);
    run_cmd(1, OP_BUMP, 8'hc7, 8'hf0, 1'b1);
    run_cmd(0, OP_READ, 8'hc7, 8'h00, 1'b1);

    // Racing bumps on one address
    run_cmd(0, OP_WRITE, 8'h81, 8'h11, 1'b1);
    repeat (8) begin
      amt_a = 8'(rand_bits(8));
      amt_b = 8'(rand_bits(8));
      fork
        run_cmd(0, OP_BUMP, 8'h81, amt_a, 1'b0);
        run_cmd(1, OP_BUMP, 8'h81, amt_b, 1'b0);
      join
    end
    run_cmd(1, OP_READ, 8'h81, 8'h00, 1'b1);
    check_display();

    fork
      run_random(0, 100);
      run_random(1, 100);
    join
    run_cmd(0, OP_READ, 8'h3c, 8'h00, 1'b1);
    check_display();

    for (int p = 0; p < 2; p++) begin
      assert (done_cnt[p] == issued[p]) else begin
        errors++;
        $display("Error at %0t: done_cnt[%0d] is %0d, expected %0d",
                 $time, p, done_cnt[p], issued[p]);
      end
    end
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== list.f ====
hdl/bus_pkg.sv
hdl/bus_master.sv
hdl/bus_arbiter.sv
hdl/word_store.sv
hdl/seg_scan.sv
hdl/shared_mem_top.sv
bench/shared_mem_sva.sv
bench/tb_shared_mem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_shared_mem \
  -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
